//--- synth_pkg.sv
`default_nettype none

package synth_pkg;

    // ------------------------------
    // sample format and amplitude
    // ------------------------------

    localparam int               SAMPLE_W   = 16;
    localparam int               Y_MAX      = 21844;    // triangle peak, below 32767
    localparam logic [15:0]      SAMPLE_MAX = 16'hffff; // top of the unsigned view
    localparam logic [15:0]      SAMPLE_MID = SAMPLE_MAX >> 1;
    localparam int               STEP_BASE  = 24;       // octave 0 increment

    // flow control and I2S framing
    localparam int CREDITS    = 4;                    // buffer depth
    localparam int BCLK_DIV   = 8;                    // clk per half bclk
    localparam int FRAME_BITS = 32;                   // 16 per channel
    localparam int BIT_CLK    = 2 * BCLK_DIV;         // clk per bit slot
    localparam int FRAME_CLK  = FRAME_BITS * BIT_CLK; // 512 clk per frame

    // ------------------------------
    // piecewise sine, ICL8038 style
    // ------------------------------

    localparam logic [15:0] SINE_BP2  = 16'((Y_MAX >> 1) + (Y_MAX >> 3)); // ~0.63
    localparam logic [15:0] SINE_BP3  = 16'((Y_MAX >> 1) + (Y_MAX >> 3) + (Y_MAX >> 2));
    localparam logic [15:0] SINE_BP1  = SINE_BP3 >> 1;                    // ~0.44
    localparam logic [15:0] SINE_OFS2 = 16'((Y_MAX >> 2) - (Y_MAX >> 5) - (Y_MAX >> 6));
    localparam logic [15:0] SINE_OFS4 = 16'(((Y_MAX >> 1) + (Y_MAX >> 2))
                                          + (((Y_MAX >> 1) + (Y_MAX >> 2)) >> 3)); // ~0.84

    // square levels, edges are Y_MAX/64 wide
    localparam logic [15:0] SQ_EDGE = 16'(Y_MAX >> 6);
    localparam logic [15:0] SQ_POS  = 16'(Y_MAX);
    localparam logic [15:0] SQ_NEG  = SAMPLE_MAX - SQ_POS;

    // one word, read signed by the oscillator and unsigned by the shapers
    typedef union packed {
        logic signed [SAMPLE_W-1:0] s;
        logic        [SAMPLE_W-1:0] u;
    } sample_u;

endpackage

`default_nettype wire

//--- triangle_osc.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_osc import synth_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] octave,
    input  logic       advance,
    output sample_u    tri_wave
);

    sample_u             acc;
    sample_u             acc_next;
    logic                down;
    logic                down_next;
    logic [SAMPLE_W-1:0] step;

    assign step = SAMPLE_W'(STEP_BASE) << octave; // octave 7 still fits below 32767

    // ------------------------------
    // next state
    // ------------------------------

    always_comb begin
        acc_next  = acc;
        down_next = down;
        if (advance) begin
            if (!down && acc.s > Y_MAX) begin
                down_next = 1'b1;                   // top reached, hold value once
            end else if (down && acc.s < -Y_MAX) begin
                down_next = 1'b0;                   // bottom reached
            end else if (down) begin
                acc_next.s = acc.s - $signed(step);
            end else begin
                acc_next.s = acc.s + $signed(step);
            end
        end
    end

    // ------------------------------
    // state registers
    // ------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc.s <= '0;
            down  <= 1'b0;
        end else begin
            acc  <= acc_next;
            down <= down_next;
        end
    end

    // the updated value goes out, so a sample loaded in the advancing
    // cycle already carries its own step
    assign tri_wave = acc_next;

endmodule

`default_nettype wire

//--- sine_shaper.sv
`timescale 1ns/1ps
`default_nettype none

module sine_shaper import synth_pkg::*; (
    input  sample_u     tri_wave,
    output logic [15:0] sine_wave
);

    logic        negative;  // lower half of the signed triangle
    logic [15:0] magnitude;
    logic [15:0] shaped;

    // one half-wave, four segments with falling slope toward the peak
    function automatic logic [15:0] shape_half(input logic [15:0] x);
        logic [15:0] x48;
        logic [15:0] x63;
        logic [15:0] y;
        x48 = (x >> 1) - (x >> 6);  // 0.48 x
        x63 = (x >> 1) + (x >> 3);  // 0.63 x
        if (x < SINE_BP1) begin
            y = x + x48;                  // 1.48 x
        end else if (x < SINE_BP2) begin
            y = x + SINE_OFS2;            // x + 0.21 y_max
        end else if (x < SINE_BP3) begin
            y = x63 + SINE_BP1;           // 0.63 x + 0.44 y_max
        end else begin
            y = (x63 >> 2) + SINE_OFS4;   // 0.16 x + 0.84 y_max
        end
        return y;
    endfunction

    // ------------------------------
    // mirror the negative half
    // ------------------------------

    assign negative  = tri_wave.u > SAMPLE_MID;
    assign magnitude = negative ? (SAMPLE_MAX - tri_wave.u) : tri_wave.u;
    assign shaped    = shape_half(magnitude);

    // fold back about SAMPLE_MAX for the lower half-wave
    assign sine_wave = negative ? (SAMPLE_MAX - shaped) : shaped;

endmodule

`default_nettype wire

//--- waveform_select.sv
`timescale 1ns/1ps
`default_nettype none

module waveform_select import synth_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  waveform,
    input  sample_u     tri_wave,
    input  logic [15:0] sine_wave,
    input  logic        load,
    output logic [15:0] sample
);

    logic [15:0] square_wave;
    logic [15:0] selected;

    // square with short ramps near the zero crossing
    always_comb begin
        if (tri_wave.u > SAMPLE_MID) begin
            if (tri_wave.u > (SAMPLE_MAX - SQ_EDGE)) begin
                square_wave = SAMPLE_MAX;
            end else begin
                square_wave = SQ_NEG;
            end
        end else begin
            if (tri_wave.u < SQ_EDGE) begin
                square_wave = '0;
            end else begin
                square_wave = SQ_POS;
            end
        end
    end

    // ------------------------------
    // one-hot waveform decode
    // ------------------------------

    always_comb begin
        case (waveform)
            4'b0001: selected = sine_wave;
            4'b0010: selected = tri_wave.u;
            4'b0100: selected = square_wave;
            default: selected = '0;       // silence
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample <= '0;
        end else if (load) begin
            sample <= selected;
        end
    end

endmodule

`default_nettype wire

//--- waveform_gen.sv
`timescale 1ns/1ps
`default_nettype none

module waveform_gen import synth_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [2:0]  octave,
    input  logic [3:0]  waveform,
    input  logic        credit_return,
    output logic        sample_valid,
    output logic [15:0] sample
);

    logic [2:0]  credits;   // free entries in the serializer buffer
    logic        spend;
    sample_u     tri_wave;
    logic [15:0] sine_wave;

    // a sample is made whenever a buffer slot is known to be free
    assign spend = (credits != 3'd0);

    // ------------------------------
    // credit counter
    // ------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= 3'(CREDITS);
        end else begin
            case ({spend, credit_return})
                2'b10:   credits <= credits - 3'd1;
                2'b01:   credits <= credits + 3'd1;
                default: credits <= credits;   // none, or one in and one out
            endcase
        end
    end

    // valid lines up with the registered sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= spend;
        end
    end

    // ------------------------------
    // datapath
    // ------------------------------

    triangle_osc i_triangle_osc (
        .clk      (clk),
        .reset    (reset),
        .octave   (octave),
        .advance  (spend),
        .tri_wave (tri_wave)
    );

    sine_shaper i_sine_shaper (
        .tri_wave  (tri_wave),
        .sine_wave (sine_wave)
    );

    waveform_select i_waveform_select (
        .clk       (clk),
        .reset     (reset),
        .waveform  (waveform),
        .tri_wave  (tri_wave),
        .sine_wave (sine_wave),
        .load      (spend),        // same cycle as the oscillator step
        .sample    (sample)
    );

endmodule

`default_nettype wire

//--- i2s_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer import synth_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        sample_valid,
    input  logic [15:0] sample,
    output logic        credit_return,
    output logic        bclk,
    output logic        lrclk,
    output logic        sdata
);

    logic [15:0] fifo_mem [0:CREDITS-1];
    logic [1:0]  wr_ptr;
    logic [1:0]  rd_ptr;
    logic [2:0]  fifo_count;
    logic        fifo_empty;

    logic [8:0]  frame_cnt;   // clk position inside the frame
    logic        slot_start;  // falling bclk, sdata may change
    logic        word_slot;   // MSB slot of either half
    logic        pop;
    logic [15:0] frame_word;  // sample sent on both channels
    logic [15:0] next_word;
    logic [15:0] shreg;

    // ------------------------------
    // sample buffer
    // ------------------------------

    assign fifo_empty = (fifo_count == 3'd0);

    // credits guarantee a free entry on every push
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            fifo_mem[wr_ptr] <= sample;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (sample_valid) wr_ptr <= wr_ptr + 2'd1;
            if (pop)          rd_ptr <= rd_ptr + 2'd1;
            case ({sample_valid, pop})
                2'b10:   fifo_count <= fifo_count + 3'd1;
                2'b01:   fifo_count <= fifo_count - 3'd1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // ------------------------------
    // frame timing
    // ------------------------------

    assign slot_start = (frame_cnt % BIT_CLK) == 0;
    assign word_slot  = (frame_cnt % (FRAME_CLK / 2)) == BIT_CLK; // one bit after lrclk
    assign pop        = (frame_cnt == BIT_CLK) && !fifo_empty;    // left half only

    always_comb begin
        next_word = frame_word;          // right half repeats the left word
        if (frame_cnt == BIT_CLK) begin
            next_word = fifo_empty ? '0 : fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (frame_cnt == BIT_CLK) begin
            frame_word <= next_word;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt     <= '0;
            bclk          <= 1'b0;
            lrclk         <= 1'b0;
            sdata         <= 1'b0;
            shreg         <= '0;
            credit_return <= 1'b0;
        end else begin
            frame_cnt     <= (frame_cnt == FRAME_CLK - 1) ? '0 : frame_cnt + 9'd1;
            bclk          <= (frame_cnt % BIT_CLK) >= BCLK_DIV;
            lrclk         <= frame_cnt >= (FRAME_CLK / 2);  // high for right channel
            credit_return <= pop;
            if (slot_start) begin
                if (word_slot) begin
                    sdata <= next_word[15];            // MSB first
                    shreg <= next_word << 1;
                end else begin
                    sdata <= shreg[15];                // LSB spills into next half
                    shreg <= shreg << 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- audio_synth_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_synth_top (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] octave,
    input  logic [3:0] waveform,
    output logic       bclk,
    output logic       lrclk,
    output logic       sdata
);

    // ------------------------------
    // generator to serializer link
    // ------------------------------

    logic        sample_valid;
    logic [15:0] sample;
    logic        credit_return;  // one pulse per buffer pop

    // pitch follows the frame rate, one sample per frame
    waveform_gen i_waveform_gen (
        .clk           (clk),
        .reset         (reset),
        .octave        (octave),
        .waveform      (waveform),
        .credit_return (credit_return),
        .sample_valid  (sample_valid),
        .sample        (sample)
    );

    // same sample on left and right
    i2s_serializer i_i2s_serializer (
        .clk           (clk),
        .reset         (reset),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .credit_return (credit_return),
        .bclk          (bclk),
        .lrclk         (lrclk),
        .sdata         (sdata)
    );

endmodule

`default_nettype wire

//--- audio_synth_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_synth_tb import synth_pkg::*; ();

    localparam int          TIMEOUT_CYC = 2000;         // clk cycles per frame wait
    localparam int          SINE_TOL    = 4;            // lsb slack for shift-add rounding
    localparam logic [31:0] SEED        = 32'hf450_6843;

    logic        clk;
    logic        reset;
    logic [2:0]  octave;
    logic [3:0]  waveform;
    logic        bclk;
    logic        lrclk;
    logic        sdata;

    int          errors = 0;
    int          checks = 0;
    int          model_acc;     // signed reference triangle
    bit          model_down;
    logic [15:0] rx_shift;
    logic [15:0] rx_left;
    logic [15:0] rx_right;
    logic        rx_lr;         // lrclk seen on the previous rising bclk
    int          frames_rx = 0;
    int          rand_oct;

    audio_synth_top i_audio_synth_top (
        .clk      (clk),
        .reset    (reset),
        .octave   (octave),
        .waveform (waveform),
        .bclk     (bclk),
        .lrclk    (lrclk),
        .sdata    (sdata)
    );

    always #50 clk = ~clk;

    // ------------------------------
    // I2S deserializer
    // ------------------------------

    // the bit after an lrclk change is still the LSB of the previous word
    always @(posedge bclk or posedge reset) begin
        if (reset) begin
            rx_shift <= '0;
            rx_lr    <= 1'b0;
        end else begin
            rx_shift <= {rx_shift[14:0], sdata};
            rx_lr    <= lrclk;
            if (lrclk != rx_lr) begin
                if (rx_lr) begin
                    rx_right  <= {rx_shift[14:0], sdata};
                    frames_rx <= frames_rx + 1;     // frame complete
                end else begin
                    rx_left <= {rx_shift[14:0], sdata};
                end
            end
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------

    task automatic model_advance(input int oct, output logic [15:0] word, output bit flipped);
        int step;
        step    = STEP_BASE << oct;
        flipped = 1'b0;
        if (!model_down && model_acc > Y_MAX) begin
            model_down = 1'b1;                      // top peak reached and value held
            flipped    = 1'b1;
        end else if (model_down && model_acc < -Y_MAX) begin
            model_down = 1'b0;
            flipped    = 1'b1;
        end else if (model_down) begin
            model_acc = model_acc - step;
        end else begin
            model_acc = model_acc + step;
        end
        word = model_acc[15:0];
    endtask

    // coefficients are the nearest short sums of powers of two
    function automatic int expected_sine(input logic [15:0] u);
        int  mag;
        real y;
        bit  neg;
        neg = (u > 16'd32767);
        mag = neg ? 65535 - int'(u) : int'(u);
        if (mag < (Y_MAX * 7) / 16) begin
            y = 1.484375 * mag;
        end else if (mag < (Y_MAX * 5) / 8) begin
            y = mag + 0.203125 * Y_MAX;
        end else if (mag < (Y_MAX * 7) / 8) begin
            y = 0.625 * mag + 0.4375 * Y_MAX;
        end else begin
            y = 0.15625 * mag + 0.84375 * Y_MAX;
        end
        return neg ? 65535 - $rtoi(y) : $rtoi(y);   // mirror about the top
    endfunction

    function automatic int expected_square(input logic [15:0] u);
        int edge_w;
        edge_w = Y_MAX / 64;
        if (u > 16'd32767) begin
            return (int'(u) > 65535 - edge_w) ? 65535 : 65535 - Y_MAX;
        end
        return (int'(u) < edge_w) ? 0 : Y_MAX;
    endfunction

    // ------------------------------
    // checks and run control
    // ------------------------------

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic compare_within(input string name, input int expected,
                                  input logic signed [31:0] actual);
        checks++;
        assert (!$isunknown(actual) && actual >= expected - SINE_TOL
                && actual <= expected + SINE_TOL) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0d (+/-%0d), actual %0d",
                     name, expected, SINE_TOL, actual);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic wait_frame();
        int start;
        int cycles;
        start  = frames_rx;
        cycles = 0;
        while (frames_rx == start) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYC) begin
                errors++;
                $display("no lrclk edge seen within %0d cycles", TIMEOUT_CYC);
                end_run();
            end
        end
    endtask

    task automatic expect_idle_outputs(input string name);
        check_value({name, " bclk"}, 0, bclk);
        check_value({name, " lrclk"}, 0, lrclk);
        check_value({name, " sdata"}, 0, sdata);
    endtask

    // octave and waveform only change while reset is held
    task automatic apply_reset(input int oct, input logic [3:0] code);
        @(negedge clk);
        reset    = 1'b1;
        octave   = oct[2:0];
        waveform = code;
        repeat (4) begin
            @(negedge clk);
            expect_idle_outputs("reset");
        end
        reset = 1'b0;
        @(negedge clk);
        expect_idle_outputs("after reset");
        model_acc  = 0;
        model_down = 1'b0;
    endtask

    task automatic run_wave(input string name, input logic [3:0] code, input int oct,
                            input int nframes, input bit check_steps);
        logic [15:0] tri_exp;
        logic [15:0] prev;
        bit          flipped;
        int          expected;
        int          step;
        int          a;
        int          b;
        step = STEP_BASE << oct;
        prev = '0;
        apply_reset(oct, code);
        for (int n = 0; n < nframes; n++) begin
            wait_frame();
            model_advance(oct, tri_exp, flipped);
            if (code == 4'b0001) begin
                compare_within({name, " left"}, expected_sine(tri_exp), rx_left);
                check_value({name, " right"}, rx_left, rx_right);
            end else begin
                case (code)
                    4'b0010: expected = tri_exp;
                    4'b0100: expected = expected_square(tri_exp);
                    default: expected = 0;              // silence
                endcase
                check_value({name, " left"}, expected, rx_left);
                check_value({name, " right"}, expected, rx_right);
            end
            if (code == 4'b0100) begin
                checks++;
                assert (rx_left == 16'd0 || rx_left == 16'(Y_MAX) || rx_left == 16'hffff
                        || rx_left == 16'(65535 - Y_MAX)) else begin
                    errors++;
                    $display("CHECK FAILED %s level: expected one of four levels, actual %0d",
                             name, rx_left);
                end
            end
            if (check_steps) begin
                a        = $signed(rx_left);
                b        = $signed(prev);
                expected = flipped ? 0 : (model_down ? -step : step);
                check_value({name, " step"}, expected, a - b);
                prev     = rx_left;
            end
        end
    endtask

    // ------------------------------
    // scenarios
    // ------------------------------

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        octave   = 3'd0;
        waveform = 4'b0000;
        rand_oct = $urandom(SEED) % 8;
        $display("random octave %0d", rand_oct);

        // octave 4 reaches both peaks well inside 300 frames
        run_wave("triangle", 4'b0010, 4, 300, 1'b0);
        run_wave("sine", 4'b0001, 4, 300, 1'b0);
        run_wave("square", 4'b0100, 4, 200, 1'b0);
        run_wave("octave", 4'b0010, rand_oct, 200, 1'b1);
        run_wave("silence 0000", 4'b0000, 4, 20, 1'b0);
        run_wave("silence 1000", 4'b1000, 4, 20, 1'b0);
        end_run();
    end

endmodule

`default_nettype wire

//--- audio_synth_top.f
synth_pkg.sv
triangle_osc.sv
sine_shaper.sv
waveform_select.sv
waveform_gen.sv
i2s_serializer.sv
audio_synth_top.sv
audio_synth_tb.sv

//--- Bender.yml
package:
  name: audio_synth

sources:
  - synth_pkg.sv
  - triangle_osc.sv
  - sine_shaper.sv
  - waveform_select.sv
  - waveform_gen.sv
  - i2s_serializer.sv
  - audio_synth_top.sv
  - target: test
    files:
      - audio_synth_tb.sv
